/* src.f */
verilog/racing_pkg.sv
verilog/scan_timing.sv
verilog/sprite_renderer.sv
verilog/game_regs.sv
verilog/playfield_mixer.sv
verilog/racing_top.sv
+incdir+verif
verif/racing_tb.sv

/* Bender.yml */
package:
  name: racing_video

sources:
  - files:
      - verilog/racing_pkg.sv
      - verilog/scan_timing.sv
      - verilog/sprite_renderer.sv
      - verilog/game_regs.sv
      - verilog/playfield_mixer.sv
      - verilog/racing_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/racing_tb.sv

/* verif/racing_model.svh */
// beam position and register mirror
int         m_h;
int         m_v;
byte_t      m_ram [64];
// sprite phase: 0 idle, 1 wait row fetch, 2 wait start column, 3 shifting
int         sp_state [2];
int         sp_row [2];
int         sp_left [2];
byte_t      sp_bits [2];
logic       sp_gfx [2];
logic       m_coll;
logic [2:0] m_rgb;

function automatic logic exp_hsync();
  return (m_h >= h_sync_start) && (m_h <= h_sync_end);
endfunction

function automatic logic exp_vsync();
  return (m_v >= v_sync_start) && (m_v <= v_sync_end);
endfunction

function automatic logic exp_display();
  return (m_h < h_display) && (m_v < v_display);
endfunction

// what the host should see at an address right now
function automatic byte_t model_read(input byte_t addr);
  if (addr < 8'd64) begin
    return m_ram[addr[5:0]];
  end
  case (addr)
    addr_in_hpos:  return m_h[7:0];
    addr_in_vpos:  return m_v[7:0];
    addr_in_flags: return {2'b00, m_coll, exp_vsync(), exp_hsync(), vpaddle, hpaddle,
                           exp_display()};
    default:       return 8'h00;
  endcase
endfunction

task automatic model_reset();
  m_h = 0;
  m_v = 0;
  foreach (m_ram[i]) begin
    m_ram[i] = 8'h00;
  end
  for (int i = 0; i < 2; i++) begin
    sp_state[i] = 0;
    sp_row[i] = 0;
    sp_left[i] = 0;
    sp_bits[i] = 8'h00;
    sp_gfx[i] = 1'b0;
  end
  m_coll = 1'b0;
  m_rgb = 3'b000;
endtask

// one clock edge, every rule reads the values from before the edge
task automatic model_step(input bus_req_t b);
  logic offside;
  logic shoulder;
  logic track;
  int   col;
  int   x;
  int   y;
  offside  = ((m_h % 256) < 32) || ((m_h % 256) >= 224);
  col      = (m_h % 256) / 8;
  shoulder = (col == 3) || (col == 28);
  track    = offside && (((m_v / 2) % 32) != ((m_ram[8] / 2) % 32));
  if (exp_display()) begin
    m_rgb = {sp_gfx[1] || shoulder, sp_gfx[0] || track, sp_gfx[0] || sp_gfx[1] || shoulder};
  end else begin
    m_rgb = 3'b000;
  end
  if (sp_gfx[0] && (sp_gfx[1] || track)) begin
    m_coll = 1'b1;
  end else if (m_v == 0) begin
    m_coll = 1'b0;
  end
  for (int i = 0; i < 2; i++) begin
    x = m_ram[2 + 2 * i];
    y = m_ram[3 + 2 * i];
    case (sp_state[i])
      0: begin
        if ((m_h == 256 + 4 * i) && (m_v == y)) begin
          sp_row[i] = 0;
          sp_bits[i] = car_bitmap[0];
          sp_state[i] = 2;
        end
      end
      1: begin
        if (m_h == 256 + 4 * i) begin
          sp_bits[i] = car_bitmap[sp_row[i]];
          sp_state[i] = 2;
        end
      end
      2: begin
        if (m_h == x) begin
          sp_gfx[i] = sp_bits[i][7];
          sp_bits[i] = sp_bits[i] << 1;
          sp_left[i] = 7;
          sp_state[i] = 3;
        end
      end
      default: begin
        if (sp_left[i] > 0) begin
          sp_gfx[i] = sp_bits[i][7];
          sp_bits[i] = sp_bits[i] << 1;
          sp_left[i] = sp_left[i] - 1;
        end else begin
          sp_gfx[i] = 1'b0;
          sp_row[i] = sp_row[i] + 1;
          sp_state[i] = (sp_row[i] == 16) ? 0 : 1;
        end
      end
    endcase
  end
  if (m_h == h_total - 1) begin
    m_h = 0;
    m_v = (m_v == v_total - 1) ? 0 : m_v + 1;
  end else begin
    m_h = m_h + 1;
  end
  if (b.we && (b.addr < 8'd64)) begin
    m_ram[b.addr[5:0]] = b.wdata;
  end
endtask

/* verif/racing_tb.sv */
`timescale 1ns/1ns

module racing_tb;

  import racing_pkg::*;

  localparam int h_display    = 256;
  localparam int h_total      = 309;
  localparam int h_sync_start = 280;
  localparam int h_sync_end   = 303;
  localparam int v_display    = 240;
  localparam int v_total      = 262;
  localparam int v_sync_start = 256;
  localparam int v_sync_end   = 259;

  localparam int frame_cycles = h_total * v_total;
  localparam int n_writes     = 300;
  // two sync frames, three sprite scenarios of up to two frames, bus traffic
  localparam int cycle_limit  = 9 * frame_cycles + 2 * n_writes + 1000;

  logic       clk;
  logic       rst_n;
  bus_req_t   bus;
  logic       hpaddle;
  logic       vpaddle;
  byte_t      rd_data;
  logic       hsync;
  logic       vsync;
  logic [2:0] rgb;

  logic [31:0] lfsr;
  int          cycles = 0;
  logic        coll_seen;

  `include "racing_model.svh"

  racing_top #(
    .h_display(h_display), .h_total(h_total),
    .h_sync_start(h_sync_start), .h_sync_end(h_sync_end),
    .v_display(v_display), .v_total(v_total),
    .v_sync_start(v_sync_start), .v_sync_end(v_sync_end)
  ) racing_top_inst (
    .clk(clk), .rst_n(rst_n), .bus(bus), .hpaddle(hpaddle), .vpaddle(vpaddle),
    .rd_data(rd_data), .hsync(hsync), .vsync(vsync), .rgb(rgb)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // starts on a falling edge and returns on the next one after the write
  task automatic bus_write(input byte_t addr, input byte_t data);
    bus = '{addr: addr, wdata: data, we: 1'b1};
    @(negedge clk);
    bus.we = 1'b0;
  endtask

  task automatic set_sprites(input byte_t px, input byte_t py, input byte_t ex,
                             input byte_t ey, input byte_t trk);
    bus_write(8'(reg_player_x), px);
    bus_write(8'(reg_player_y), py);
    bus_write(8'(reg_enemy_x), ex);
    bus_write(8'(reg_enemy_y), ey);
    bus_write(8'(reg_trackpos_lo), trk);
  endtask

  task automatic watch_flags(input int n);
    bus = '{addr: addr_in_flags, wdata: 8'h00, we: 1'b0};
    repeat (n) begin
      @(negedge clk);
      check_value("rd_data flags", rd_data, model_read(bus.addr));
      if (m_coll && (m_v != 0)) begin
        coll_seen = 1'b1;
      end
    end
  endtask

  task automatic run_one_frame();
    while ((m_h != 0) || (m_v != 0)) begin
      watch_flags(1);
    end
    coll_seen = 1'b0;
    watch_flags(frame_cycles);
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      model_reset();
    end else begin
      model_step(bus);
    end
  end

  // pin checks on every cycle and the run limit
  always @(negedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("TESTBENCH FAILED");
      $fatal(1, "run limit reached");
    end else if (rst_n) begin
      check_value("hsync", hsync, exp_hsync());
      check_value("vsync", vsync, exp_vsync());
      check_value("rgb", rgb, m_rgb);
    end
  end

  initial begin
    logic [31:0] r;
    byte_t       a;
    byte_t       d;
    byte_t       x;
    byte_t       y;
    bus = '0;
    hpaddle = 1'b0;
    vpaddle = 1'b0;
    rst_n = 1'b0;
    lfsr = 32'h5ade_dff4;
    coll_seen = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // sync, position and flag reads for two frames
    for (int i = 0; i < 2 * frame_cycles; i++) begin
      @(negedge clk);
      check_value("rd_data", rd_data, model_read(bus.addr));
      r = take_bits(3);
      bus.addr = (i % 2 == 0) ? addr_in_flags : (r[2] ? addr_in_vpos : addr_in_hpos);
      hpaddle = r[0];
      vpaddle = r[1];
    end

    // random writes over the whole address space
    repeat (n_writes) begin
      a = take_bits(8);
      d = take_bits(8);
      bus_write(a, d);
      check_value("rd_data after write", rd_data, (a < 8'd64) ? d : model_read(a));
    end
    for (int i = 0; i < 256; i++) begin
      bus.addr = 8'(i);
      @(negedge clk);
      check_value("rd_data sweep", rd_data, model_read(bus.addr));
    end

    // random sprites and track
    set_sprites(take_bits(8) % 240, 32 + take_bits(8) % 192, take_bits(8) % 240,
                32 + take_bits(8) % 192, take_bits(8));
    run_one_frame();

    // player placed on the enemy
    x = take_bits(8) % 240;
    y = 32 + take_bits(8) % 192;
    set_sprites(x, y, x, y, take_bits(8));
    run_one_frame();
    check_value("collision seen", coll_seen, 1'b1);

    // player in the middle of the road and clear of the enemy
    set_sprites(8'd100, 8'd100, 8'd100, 8'd10, take_bits(8));
    run_one_frame();
    check_value("collision in clear frame", coll_seen, 1'b0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* verilog/racing_top.sv */
`timescale 1ns/1ns

module racing_top #(
  parameter int h_display    = 256,
  parameter int h_total      = 309,
  parameter int h_sync_start = 280,
  parameter int h_sync_end   = 303,
  parameter int v_display    = 240,
  parameter int v_total      = 262,
  parameter int v_sync_start = 256,
  parameter int v_sync_end   = 259
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  racing_pkg::bus_req_t bus,
  input  logic                 hpaddle,
  input  logic                 vpaddle,
  output racing_pkg::byte_t    rd_data,
  output logic                 hsync,
  output logic                 vsync,
  output logic [2:0]           rgb
);

  import racing_pkg::*;

  scan_pos_t   pos;
  sprite_pos_t player_pos;
  sprite_pos_t enemy_pos;
  byte_t       track_lo;
  logic        player_gfx;
  logic        enemy_gfx;
  logic        collision;

  scan_timing #(
    .h_display(h_display), .h_total(h_total),
    .h_sync_start(h_sync_start), .h_sync_end(h_sync_end),
    .v_display(v_display), .v_total(v_total),
    .v_sync_start(v_sync_start), .v_sync_end(v_sync_end)
  ) scan_timing_inst (.clk(clk), .rst_n(rst_n), .pos(pos));

  // staggered fetch points keep the two loads apart
  sprite_renderer #(.load_hpos(256)) player_renderer_inst (
    .clk(clk), .rst_n(rst_n), .pos(pos), .sprite(player_pos), .gfx(player_gfx)
  );

  sprite_renderer #(.load_hpos(260)) enemy_renderer_inst (
    .clk(clk), .rst_n(rst_n), .pos(pos), .sprite(enemy_pos), .gfx(enemy_gfx)
  );

  game_regs game_regs_inst (
    .clk(clk), .rst_n(rst_n), .bus(bus), .pos(pos),
    .hpaddle(hpaddle), .vpaddle(vpaddle), .collision(collision),
    .rd_data(rd_data), .player_pos(player_pos), .enemy_pos(enemy_pos),
    .track_lo(track_lo)
  );

  playfield_mixer #(.h_display(h_display), .v_display(v_display)) playfield_mixer_inst (
    .clk(clk), .rst_n(rst_n), .pos(pos),
    .player_gfx(player_gfx), .enemy_gfx(enemy_gfx), .track_lo(track_lo),
    .rgb(rgb), .collision(collision)
  );

  assign hsync = pos.hsync;
  assign vsync = pos.vsync;

endmodule

/* verilog/playfield_mixer.sv */
`timescale 1ns/1ns

module playfield_mixer #(
  parameter int h_display = 256,
  parameter int v_display = 240
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  racing_pkg::scan_pos_t pos,
  input  logic                  player_gfx,
  input  logic                  enemy_gfx,
  input  racing_pkg::byte_t     track_lo,
  output logic [2:0]            rgb,
  output logic                  collision
);

  logic track_offside;
  logic track_shoulder;
  logic track_gfx;
  logic r;
  logic g;
  logic b;

  // grass on both outer edges, shoulder stripes inside them
  assign track_offside  = (pos.hpos[7:5] == 3'd0) || (pos.hpos[7:5] == 3'd7);
  assign track_shoulder = (pos.hpos[7:3] == 5'd3) || (pos.hpos[7:3] == 5'd28);
  // stripes scroll with the track position
  assign track_gfx      = track_offside && (pos.vpos[5:1] != track_lo[5:1]);

  assign r = pos.display_on && (player_gfx || enemy_gfx || track_shoulder);
  assign g = pos.display_on && (player_gfx || track_gfx);
  assign b = pos.display_on && (enemy_gfx || track_shoulder);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rgb <= 3'b000;
    end else begin
      rgb <= {b, g, r};
    end
  end

  // hit anywhere in the frame, cleared on line 0 unless hit again
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      collision <= 1'b0;
    end else if (player_gfx && (enemy_gfx || track_gfx)) begin
      collision <= 1'b1;
    end else if (pos.vpos == '0) begin
      collision <= 1'b0;
    end
  end

  a_black_in_blanking: assert property (
    @(posedge clk) disable iff (!rst_n)
    !((pos.hpos < h_display) && (pos.vpos < v_display)) |=> (rgb == 3'b000)
  );

endmodule

/* verilog/game_regs.sv */
`timescale 1ns/1ns

module game_regs (
  input  logic                    clk,
  input  logic                    rst_n,
  input  racing_pkg::bus_req_t    bus,
  input  racing_pkg::scan_pos_t   pos,
  input  logic                    hpaddle,
  input  logic                    vpaddle,
  input  logic                    collision,
  output racing_pkg::byte_t       rd_data,
  output racing_pkg::sprite_pos_t player_pos,
  output racing_pkg::sprite_pos_t enemy_pos,
  output racing_pkg::byte_t       track_lo
);

  import racing_pkg::*;

  byte_t   ram [64];
  status_u status;
  logic    ram_sel;

  // RAM occupies 0x00 to 0x3f
  assign ram_sel = (bus.addr[7:6] == 2'b00);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 64; i++) begin
        ram[i] <= '0;
      end
    end else if (bus.we && ram_sel) begin
      ram[bus.addr[5:0]] <= bus.wdata;
    end
  end

  assign status.flags = '{
    spare:      2'b00,
    collision:  collision,
    vsync:      pos.vsync,
    hsync:      pos.hsync,
    vpaddle:    vpaddle,
    hpaddle:    hpaddle,
    display_on: pos.display_on
  };

  always_comb begin
    rd_data = '0;
    if (ram_sel) begin
      rd_data = ram[bus.addr[5:0]];
    end else begin
      case (bus.addr)
        addr_in_hpos:  rd_data = pos.hpos[7:0];
        addr_in_vpos:  rd_data = pos.vpos[7:0];
        addr_in_flags: rd_data = status.raw;
        default:       rd_data = '0;
      endcase
    end
  end

  // registers the video side reads every line
  assign player_pos = '{x: ram[reg_player_x], y: ram[reg_player_y]};
  assign enemy_pos  = '{x: ram[reg_enemy_x], y: ram[reg_enemy_y]};
  assign track_lo   = ram[reg_trackpos_lo];

  for (genvar g = 0; g < 64; g++) begin : g_ram_chk
    a_no_stray_write: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(bus.we && (bus.addr == 8'(g))) |=> $stable(ram[g])
    );
  end

endmodule

/* verilog/sprite_renderer.sv */
`timescale 1ns/1ns

module sprite_renderer #(
  parameter int load_hpos = 256
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  racing_pkg::scan_pos_t   pos,
  input  racing_pkg::sprite_pos_t sprite,
  output logic                    gfx
);

  import racing_pkg::*;

  localparam logic [1:0] st_wait_line   = 2'd0;
  localparam logic [1:0] st_wait_load   = 2'd1;
  localparam logic [1:0] st_wait_hstart = 2'd2;
  localparam logic [1:0] st_draw        = 2'd3;

  logic [1:0] state;
  logic [4:0] row;
  logic [3:0] bit_cnt;
  byte_t      shifter;
  logic       load;
  logic       on_line;
  logic       hstart;
  logic       fetch_first;
  logic       fetch_next;
  logic       shift_en;

  assign load    = (pos.hpos == pos_w'(load_hpos));
  assign on_line = (pos.vpos == {1'b0, sprite.y});
  assign hstart  = (pos.hpos == {1'b0, sprite.x});

  assign fetch_first = (state == st_wait_line) && load && on_line;
  assign fetch_next  = (state == st_wait_load) && load;
  assign shift_en    = ((state == st_wait_hstart) && hstart) ||
                       ((state == st_draw) && (bit_cnt != 4'd8));

  // row bits, loaded at the fetch hpos and shifted out msb first
  always_ff @(posedge clk) begin
    if (fetch_first) begin
      shifter <= car_bitmap[0];
    end else if (fetch_next) begin
      shifter <= car_bitmap[row[3:0]];
    end else if (shift_en) begin
      shifter <= {shifter[6:0], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_wait_line;
      row     <= '0;
      bit_cnt <= '0;
      gfx     <= 1'b0;
    end else begin
      case (state)
        st_wait_line: begin
          if (fetch_first) begin
            row   <= '0;
            state <= st_wait_hstart;
          end
        end
        st_wait_load: begin
          if (load) begin
            state <= st_wait_hstart;
          end
        end
        st_wait_hstart: begin
          if (hstart) begin
            gfx     <= shifter[7];
            bit_cnt <= 4'd1;
            state   <= st_draw;
          end
        end
        default: begin
          if (bit_cnt == 4'd8) begin
            gfx <= 1'b0;
            // last row done, wait for the next frame
            if (row == 5'd15) begin
              state <= st_wait_line;
            end else begin
              row   <= row + 1'b1;
              state <= st_wait_load;
            end
          end else begin
            gfx     <= shifter[7];
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  a_draw_row_valid: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state != st_draw) ##1 (state == st_draw) |-> (row < 5'd16)
  );

endmodule

/* verilog/scan_timing.sv */
`timescale 1ns/1ns

module scan_timing #(
  parameter int h_display    = 256,
  parameter int h_total      = 309,
  parameter int h_sync_start = 280,
  parameter int h_sync_end   = 303,
  parameter int v_display    = 240,
  parameter int v_total      = 262,
  parameter int v_sync_start = 256,
  parameter int v_sync_end   = 259
) (
  input  logic                  clk,
  input  logic                  rst_n,
  output racing_pkg::scan_pos_t pos
);

  import racing_pkg::*;

  logic [pos_w-1:0] h_cnt;
  logic [pos_w-1:0] v_cnt;
  logic             h_last;
  logic             v_last;

  assign h_last = (h_cnt == pos_w'(h_total - 1));
  assign v_last = (v_cnt == pos_w'(v_total - 1));

  // beam counters, vertical steps on the horizontal wrap
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      if (h_last) begin
        h_cnt <= '0;
        if (v_last) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // sync and blanking decoded straight from the counters
  assign pos.hpos       = h_cnt;
  assign pos.vpos       = v_cnt;
  assign pos.hsync      = (h_cnt >= pos_w'(h_sync_start)) && (h_cnt <= pos_w'(h_sync_end));
  assign pos.vsync      = (v_cnt >= pos_w'(v_sync_start)) && (v_cnt <= pos_w'(v_sync_end));
  assign pos.display_on = (h_cnt < pos_w'(h_display)) && (v_cnt < pos_w'(v_display));

  // beam stays inside the frame
  a_pos_in_frame: assert property (
    @(posedge clk) disable iff (!rst_n)
    (h_cnt < pos_w'(h_total)) && (v_cnt < pos_w'(v_total))
  );

endmodule

/* verilog/racing_pkg.sv */
package racing_pkg;

  // beam position width
  localparam int pos_w = 9;

  typedef logic [7:0] byte_t;

  // RAM bytes read by the video hardware
  localparam logic [5:0] reg_player_x    = 6'd2;
  localparam logic [5:0] reg_player_y    = 6'd3;
  localparam logic [5:0] reg_enemy_x     = 6'd4;
  localparam logic [5:0] reg_enemy_y     = 6'd5;
  localparam logic [5:0] reg_trackpos_lo = 6'd8;

  // read-only status registers
  localparam byte_t addr_in_hpos  = 8'h40;
  localparam byte_t addr_in_vpos  = 8'h41;
  localparam byte_t addr_in_flags = 8'h42;

  typedef struct packed {
    logic [pos_w-1:0] hpos;
    logic [pos_w-1:0] vpos;
    logic             display_on;
    logic             hsync;
    logic             vsync;
  } scan_pos_t;

  typedef struct packed {
    byte_t addr;
    byte_t wdata;
    logic  we;
  } bus_req_t;

  typedef struct packed {
    logic [1:0] spare;
    logic       collision;
    logic       vsync;
    logic       hsync;
    logic       vpaddle;
    logic       hpaddle;
    logic       display_on;
  } game_flags_t;

  // flags byte, seen raw by the bus and by field when built
  typedef union packed {
    byte_t       raw;
    game_flags_t flags;
  } status_u;

  typedef struct packed {
    byte_t x;
    byte_t y;
  } sprite_pos_t;

  // car seen from above, row 0 at the top
  localparam byte_t car_bitmap [16] = '{
    8'b00001100, 8'b11001100, 8'b11001100, 8'b11111100,
    8'b11101100, 8'b11100000, 8'b01100000, 8'b01110000,
    8'b00110000, 8'b00110000, 8'b00110000, 8'b01101110,
    8'b11101110, 8'b11111110, 8'b11101110, 8'b00101110
  };

endpackage
